/* verilog/fir_dsp_pkg.sv */
/*
  Number formats and constants of the filter arithmetic.
  The 16 taps are fixed. The table is a symmetric lowpass with a DC gain
  slightly above one, so full-scale DC input saturates at the output.
  Results are scaled by 2**-17 with round half up.
*/
package fir_dsp_pkg;

  localparam int SAMPLE_W = 16; // input and output sample width.
  localparam int COEFF_W  = 18; // coefficient width, signed.
  localparam int ACC_W    = 40; // accumulator width, ample headroom for 16 taps.

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEFF_W-1:0]  coeff_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  localparam int NUM_TAPS = 16;

  typedef logic [$clog2(NUM_TAPS)-1:0] tap_idx_t;

  // coefficients in tap order, tap 0 weights the newest sample.
  // the sum is 162000 against a unity gain of 131072.
  localparam coeff_t COEFF_TABLE [NUM_TAPS] = '{
    -18'sd1200,
    -18'sd2100,
    -18'sd1500,
    18'sd2600,
    18'sd9800,
    18'sd18400,
    18'sd25700,
    18'sd29300,
    18'sd29300,
    18'sd25700,
    18'sd18400,
    18'sd9800,
    18'sd2600,
    -18'sd1500,
    -18'sd2100,
    -18'sd1200
  };

  localparam int   ROUND_SHIFT = 17;                              // result scaling.
  localparam acc_t ROUND_BIAS  = acc_t'(1) <<< (ROUND_SHIFT - 1); // half an output LSB.

  // saturation limits of the output sample.
  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

/* verilog/fir_ctrl_pkg.sv */
/*
  Control types shared by the sequencer and the MAC.
  The MAC control word travels one cycle behind the tap address.
*/
package fir_ctrl_pkg;

  // states of the pass sequencer.
  typedef enum logic [2:0] {
    IDLE,  // waiting for a full batch and a free output slot.
    ADDR,  // tap 0 on the address lines.
    PRIME, // first coefficient and sample are registering.
    RUN,   // one tap per cycle.
    FLUSH  // last product lands in the MAC.
  } seq_state_e;

  // phases of the output slot and its four-phase handshake.
  typedef enum logic [1:0] {
    EMPTY,  // slot free.
    OFFER,  // result held, out_req high.
    RETIRE  // ack seen, waiting for ack to drop.
  } hs_phase_e;

  // per-cycle command to the MAC, aligned with the registered read data.
  typedef struct packed {
    logic valid; // a product is to be accumulated.
    logic first; // restart the accumulator with this product.
    logic last;  // round, saturate and load the output slot.
  } mac_ctrl_t;

endpackage

/* verilog/fir_coeff_rom.sv */
/*
  Coefficient ROM with one cycle of read latency.
  The output has no reset. It is only used when the delayed MAC control
  word marks it valid.
*/
module fir_coeff_rom
  import fir_dsp_pkg::*;
(
  input  logic     clock,
  input  tap_idx_t tap,
  output coeff_t   coeff
);

  // the table is a constant, so this maps onto a ROM or LUTs.
  // one register stage keeps the read aligned with the sample memory,
  // which is also read through a register.
  always_ff @(posedge clock)
  begin
    coeff <= COEFF_TABLE[tap]; // read the coefficient for this tap.
  end

endmodule

/* verilog/fir_sample_ring.sv */
/*
  Input handshake, 16-deep sample history and batch counter.
  DECIMATION must be in 1..8. No sample is accepted while hold is high or
  while a finished batch waits for its pass, so the history is frozen for
  the whole MAC pass. The history clears to zero on reset.
*/
module fir_sample_ring
  import fir_dsp_pkg::*;
#(
  parameter int DECIMATION = 2
)
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     in_req,
  input  sample_t  in_data,
  output logic     in_ack,
  input  logic     hold,
  input  logic     pass_start,
  input  tap_idx_t tap,
  output logic     batch_ready,
  output sample_t  sample
);

  localparam int CNT_W = $clog2(DECIMATION + 1);

  sample_t    mem [NUM_TAPS]; // circular history.
  tap_idx_t   wr_ptr;         // next slot to write, wraps with the tap width.
  logic [CNT_W-1:0] count;    // samples of the current batch.
  logic       accept;

  if (DECIMATION < 1 || DECIMATION > 8)
  begin : g_bad_decimation
    $error("DECIMATION must be between 1 and 8");
  end

  // a new request is taken only with ack low, no pass running and no batch pending.
  assign accept = in_req && !in_ack && !hold && !batch_ready;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      in_ack      <= 1'b0;
      batch_ready <= 1'b0;
      wr_ptr      <= '0;
      count       <= '0;
      for (int i = 0; i < NUM_TAPS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else
    begin
      if (accept)
      begin
        mem[wr_ptr] <= in_data; // write the sample and acknowledge in the same edge.
        wr_ptr      <= wr_ptr + 1'b1;
        in_ack      <= 1'b1;
        if (count == CNT_W'(DECIMATION - 1))
        begin
          count       <= '0;
          batch_ready <= 1'b1; // the batch is complete.
        end
        else
        begin
          count <= count + 1'b1;
        end
      end
      else if (in_ack && !in_req)
      begin
        in_ack <= 1'b0; // source has released, close the handshake.
      end
      if (pass_start)
      begin
        batch_ready <= 1'b0; // never coincides with accept, since accept needs it low.
      end
    end
  end

  // tap 0 is the newest sample, tap 15 the oldest.
  always_ff @(posedge clock)
  begin
    sample <= mem[wr_ptr - 1'b1 - tap];
  end

  // the sequencer never leaves IDLE on the edge that raises the ack.
  a_ack_not_in_hold: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(in_ack) |-> !hold);

  a_ack_falls_after_req: assert property (@(posedge clock) disable iff (!arst_n)
    $fell(in_ack) |-> !$past(in_req));

endmodule

/* verilog/fir_coeff_seq.sv */
/*
  Pass sequencer for one MAC pass over the 16 newest samples.
  A pass starts only with a batch ready and the output slot free.
  pass_start is a one-cycle pulse during ADDR. The result is offered
  NUM_TAPS+3 cycles after it. coeff leaves one cycle after tap.
*/
module fir_coeff_seq
  import fir_dsp_pkg::*;
  import fir_ctrl_pkg::*;
(
  input  logic      clock,
  input  logic      arst_n,
  input  logic      batch_ready,
  input  logic      slot_busy,
  output logic      pass_start,
  output logic      hold,
  output tap_idx_t  tap,
  output mac_ctrl_t mac_ctrl,
  output coeff_t    coeff
);

  localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

  seq_state_e state;
  mac_ctrl_t  run_ctrl; // control word aligned with the current tap.

  // the ROM sees the same tap as the sample memory.
  fir_coeff_rom u_coeff_rom (
    .clock (clock),
    .tap   (tap),
    .coeff (coeff)
  );

  // the history must not move from the start decision until the pass ends.
  assign hold = (state != IDLE);

  // one product per RUN cycle. first and last mark the two ends of the tap range.
  always_comb
  begin
    run_ctrl.valid = (state == RUN);
    run_ctrl.first = (state == RUN) && (tap == '0);
    run_ctrl.last  = (state == RUN) && (tap == LAST_TAP);
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= IDLE;
      tap        <= '0;
      pass_start <= 1'b0;
      mac_ctrl   <= '0;
    end
    else
    begin
      pass_start <= 1'b0;
      mac_ctrl   <= run_ctrl; // delayed to meet the registered read data.
      case (state)
        IDLE:
        begin
          if (batch_ready && !slot_busy)
          begin
            tap        <= '0;
            pass_start <= 1'b1; // high during ADDR, clears batch_ready.
            state      <= ADDR;
          end
        end

        ADDR:
        begin
          state <= PRIME; // tap 0 is read into both output registers.
        end

        PRIME:
        begin
          // tap 0 data is now at the registers. the address starts stepping in RUN,
          // so the control word for tap 0 leaves in the first RUN cycle.
          state <= RUN;
        end

        RUN:
        begin
          tap <= tap + 1'b1; // wraps back to 0 after the last tap.
          if (tap == LAST_TAP)
          begin
            state <= FLUSH;
          end
        end

        FLUSH:
        begin
          state <= IDLE; // last product and the slot load happen here.
        end

        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // a pass may only overwrite an output slot that has been fully retired.
  a_start_slot_free: assert property (@(posedge clock) disable iff (!arst_n)
    pass_start |-> !slot_busy);

endmodule

/* verilog/fir_mac.sv */
/*
  Multiply-accumulate, rounding, saturation and the output slot.
  The slot holds one result and offers it over a four-phase handshake.
  A new result must only arrive while the slot is EMPTY.
*/
module fir_mac
  import fir_dsp_pkg::*;
  import fir_ctrl_pkg::*;
(
  input  logic      clock,
  input  logic      arst_n,
  input  mac_ctrl_t mac_ctrl,
  input  sample_t   sample,
  input  coeff_t    coeff,
  output logic      slot_busy,
  output logic      out_req,
  output sample_t   out_data,
  input  logic      out_ack
);

  hs_phase_e phase;
  acc_t      acc;      // running sum, restarted by first.
  acc_t      product;
  acc_t      sum;      // sum including the current product.
  acc_t      rounded;
  sample_t   result;
  logic      load;

  assign product = acc_t'(sample) * acc_t'(coeff); // both operands sign-extend.
  assign sum     = (mac_ctrl.first ? '0 : acc) + product;
  assign rounded = (sum + ROUND_BIAS) >>> ROUND_SHIFT; // round half up.
  assign load    = mac_ctrl.valid && mac_ctrl.last;

  // clip to the output range.
  always_comb
  begin
    if (rounded > acc_t'(SAMPLE_MAX))
      result = SAMPLE_MAX;
    else if (rounded < acc_t'(SAMPLE_MIN))
      result = SAMPLE_MIN;
    else
      result = sample_t'(rounded);
  end

  always_ff @(posedge clock)
  begin
    if (mac_ctrl.valid)
      acc <= sum;
    if (load)
      out_data <= result; // held until the next load.
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      phase <= EMPTY;
    else
    begin
      case (phase)
        EMPTY:   if (load) phase <= OFFER;
        OFFER:   if (out_ack) phase <= RETIRE;
        RETIRE:  if (!out_ack) phase <= EMPTY;
        default: phase <= EMPTY;
      endcase
    end
  end

  assign out_req   = (phase == OFFER);
  assign slot_busy = (phase != EMPTY);

  a_data_stable: assert property (@(posedge clock) disable iff (!arst_n)
    out_req && !out_ack |=> $stable(out_data));

  // the sequencer only starts a pass into an empty slot.
  a_load_into_empty: assert property (@(posedge clock) disable iff (!arst_n)
    load |-> phase == EMPTY);

endmodule

/* verilog/fir_decimator.sv */
/*
  Decimating 16-tap FIR stage.
  One result per DECIMATION input samples, DECIMATION in 1..8.
  Both req/ack handshakes are four-phase and synchronous to clock.
  A result waiting on out_ack stalls the next pass, and input back-pressure
  follows once the next batch has filled.
*/
module fir_decimator
  import fir_dsp_pkg::*;
  import fir_ctrl_pkg::*;
#(
  parameter int DECIMATION = 2
)
(
  input  logic    clock,
  input  logic    arst_n,
  input  logic    in_req,
  input  sample_t in_data,
  output logic    in_ack,
  output logic    out_req,
  output sample_t out_data,
  input  logic    out_ack
);

  logic      batch_ready; // ring has a full batch.
  logic      pass_start;  // sequencer took the batch.
  logic      hold;        // pass running, history frozen.
  logic      slot_busy;   // output slot not yet retired.
  tap_idx_t  tap;
  sample_t   sample;      // history read, one cycle after tap.
  coeff_t    coeff;       // coefficient read, one cycle after tap.
  mac_ctrl_t mac_ctrl;    // control aligned with sample and coeff.

  fir_sample_ring #(
    .DECIMATION (DECIMATION)
  ) u_sample_ring (
    .clock       (clock),
    .arst_n      (arst_n),
    .in_req      (in_req),
    .in_data     (in_data),
    .in_ack      (in_ack),
    .hold        (hold),
    .pass_start  (pass_start),
    .tap         (tap),
    .batch_ready (batch_ready),
    .sample      (sample)
  );

  fir_coeff_seq u_coeff_seq (
    .clock       (clock),
    .arst_n      (arst_n),
    .batch_ready (batch_ready),
    .slot_busy   (slot_busy),
    .pass_start  (pass_start),
    .hold        (hold),
    .tap         (tap),
    .mac_ctrl    (mac_ctrl),
    .coeff       (coeff)
  );

  fir_mac u_mac (
    .clock     (clock),
    .arst_n    (arst_n),
    .mac_ctrl  (mac_ctrl),
    .sample    (sample),
    .coeff     (coeff),
    .slot_busy (slot_busy),
    .out_req   (out_req),
    .out_data  (out_data),
    .out_ack   (out_ack)
  );

endmodule

/* test/fir_decimator_tb.sv */
/*
  Testbench for the decimating FIR stage, run with DECIMATION 2.
  Samples, ack delays and expected results come from test/fir_tests.txt,
  so the simulator must start in the project root. The run stops at the first error.
*/
module fir_decimator_tb
  import fir_dsp_pkg::*;
();

  localparam int          DECIMATION = 2;
  localparam logic [15:0] LFSR_SEED  = 16'd15086;

  logic    clock;
  logic    arst_n;
  logic    in_req;
  sample_t in_data;
  logic    in_ack;
  logic    out_req;
  sample_t out_data;
  logic    out_ack;

  logic [15:0] samples_q [$]; // input samples in file order.
  logic [15:0] expect_q [$];  // expected results in file order.
  int          wait_q [$];    // largest ack delay for each result.
  logic [15:0] lfsr;
  logic        in_ack_q = 1'b0;
  int          accepted = 0;  // samples acknowledged so far.
  int          cycle_count = 0;
  int          cycle_limit = 0;

  fir_decimator #(
    .DECIMATION (DECIMATION)
  ) u_dut (
    .clock    (clock),
    .arst_n   (arst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  always #2 clock = ~clock;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected)
      abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
  endtask

  // 16-bit Fibonacci LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  // picks a delay in 0..max_delay, one LFSR step per bit taken.
  task automatic draw_delay(input int max_delay, output int delay);
    int bits;
    int value;
    bits  = 0;
    value = 0;
    while ((1 << bits) <= max_delay)
      bits++;
    for (int i = 0; i < bits; i++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = (value << 1) | lfsr[0];
    end
    delay = value % (max_delay + 1);
  endtask

  task automatic read_tests(output int max_wait);
    int          fd;
    int          tag;
    int          count;
    int          current_wait;
    logic [15:0] value;
    fd = $fopen("test/fir_tests.txt", "r");
    if (fd == 0)
      abort_run("could not open test/fir_tests.txt");
    current_wait = 0;
    max_wait     = 0;
    tag          = $fgetc(fd);
    while (tag != -1)
    begin
      if (tag == "#")
      begin
        while (tag != -1 && tag != "\n")
          tag = $fgetc(fd); // skip the rest of a comment line.
      end
      else if (tag == "W")
      begin
        if ($fscanf(fd, "%d", current_wait) != 1)
          abort_run("a W line in the tests file has no delay");
        if (current_wait > max_wait)
          max_wait = current_wait;
      end
      else if (tag == "S" || tag == "E")
      begin
        if ($fscanf(fd, "%d", count) != 1)
          abort_run("an S or E line in the tests file has no count");
        repeat (count)
        begin
          if ($fscanf(fd, "%h", value) != 1)
            abort_run("an S or E line in the tests file is short of values");
          if (tag == "S")
            samples_q.push_back(value);
          else
          begin
            expect_q.push_back(value);
            wait_q.push_back(current_wait); // each result keeps the W in force.
          end
        end
      end
      else if (tag != " " && tag != "\n" && tag != "\r" && tag != "\t")
        abort_run("the tests file holds a line with an unknown tag");
      if (tag != -1)
        tag = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // four-phase source. Each call starts and ends on a rising edge.
  task automatic feed_samples();
    foreach (samples_q[i])
    begin
      in_req  <= 1'b1;
      in_data <= samples_q[i];
      @(posedge clock);
      while (!in_ack)
        @(posedge clock); // waits out back-pressure from a pending batch.
      in_req <= 1'b0;
      @(posedge clock);
      while (in_ack)
        @(posedge clock);
    end
  endtask

  task automatic collect_outputs();
    logic [15:0] held;
    int          delay;
    foreach (expect_q[i])
    begin
      @(posedge clock);
      while (!out_req)
        @(posedge clock);
      held = out_data;
      check_value("out_data", held, expect_q[i]);
      // the result needs its whole batch, and only one more batch fits behind it.
      if (accepted < DECIMATION * (i + 1) || accepted > DECIMATION * (i + 2))
        abort_run("the number of accepted samples does not fit the result count");
      draw_delay(wait_q[i], delay);
      repeat (delay)
      begin
        @(posedge clock);
        check_value("out_req", out_req, 16'd1);
        check_value("out_data", out_data, held); // held steady until the ack.
        if (accepted > DECIMATION * (i + 2))
          abort_run("input was accepted past a held result and a full batch");
      end
      out_ack <= 1'b1;
      @(posedge clock);
      while (out_req)
        @(posedge clock);
      out_ack <= 1'b0;
    end
  endtask

  // counts accepted samples and bounds the run length.
  always @(posedge clock)
  begin
    in_ack_q <= in_ack;
    if (in_ack && !in_ack_q)
      accepted <= accepted + 1;
    if (arst_n)
      cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      abort_run("timeout because the DUT did not deliver every result in time");
  end

  initial
  begin
    int max_wait;
    clock   = 1'b0;
    arst_n  = 1'b0;
    in_req  = 1'b0;
    in_data = '0;
    out_ack = 1'b0;
    lfsr    = LFSR_SEED;
    read_tests(max_wait);
    if (expect_q.size() == 0 || samples_q.size() != DECIMATION * expect_q.size())
      abort_run("the tests file does not hold one result per batch of samples");
    cycle_limit = samples_q.size() * 8 + expect_q.size() * (NUM_TAPS + 3 + max_wait) + 100;
    repeat (8)
      @(posedge clock);
    arst_n <= 1'b1;
    @(posedge clock);
    check_value("in_ack", in_ack, 16'd0);
    check_value("out_req", out_req, 16'd0);
    fork
      feed_samples();
      collect_outputs();
    join
    // no batch is left, so any further out_req is a spurious result.
    repeat (2 * (NUM_TAPS + 3))
    begin
      @(posedge clock);
      if (out_req)
        abort_run("an extra result was offered after the last expected one");
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* all.f */
verilog/fir_dsp_pkg.sv
verilog/fir_ctrl_pkg.sv
verilog/fir_coeff_rom.sv
verilog/fir_sample_ring.sv
verilog/fir_coeff_seq.sv
verilog/fir_mac.sv
verilog/fir_decimator.sv
test/fir_decimator_tb.sv

/* Bender.yml */
package:
  name: fir_decimator

sources:
  - verilog/fir_dsp_pkg.sv
  - verilog/fir_ctrl_pkg.sv
  - verilog/fir_coeff_rom.sv
  - verilog/fir_sample_ring.sv
  - verilog/fir_coeff_seq.sv
  - verilog/fir_mac.sv
  - verilog/fir_decimator.sv
  - target: test
    files:
      - test/fir_decimator_tb.sv

/* test/fir_tests.txt */
# Each line holds a tag, a count and that many hex values. S lists input samples and E results.
# W n sets the largest out_ack delay in cycles for the results after it.
# The taps from tap 0 are -1200 -2100 -1500 2600 9800 18400 25700 29300
# then 29300 25700 18400 9800 2600 -1500 -2100 -1200. Results round half up and shift by 17.
# An impulse of 0x4000 at sample 0 gives the odd taps and one at sample 17 the even taps.
W 3
S 16 4000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S 16 0000 4000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 8 fefa 0145 08fc 0e4f 0c8d 04c9 ff45 ff6a
E 8 ff6a ff45 04c9 0c8d 0e4f 08fc 0145 fefa
# Positive full scale ramps up through the taps and then saturates.
W 20
S 16 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
S 16 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
E 16 fcc7 fdda 1964 4f19 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
# Negative full scale follows the positive run, so the window mixes both at first.
W 12
S 16 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
S 16 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
E 16 7fff 7fff 6b6b ffff 9494 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
